//--- Makefile
# Verilator build and run of the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= conv_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
hw/conv_pkg.sv
hw/conv_ctrl.sv
hw/conv_loader.sv
hw/conv_window.sv
hw/conv_mac.sv
hw/conv_out.sv
hw/conv_top.sv
dv/conv_checker.sv
dv/conv_tb.sv

//--- dv/conv_checker.sv
// Checks stream protocol and the done pulse only and leaves data values to the testbench
`timescale 1ns/1ps

module conv_checker import conv_pkg::*; (
  input logic   clk,
  input logic   arst_n_in,
  input pixel_t kernel_data,
  input logic   kernel_valid,
  input logic   kernel_ready,
  input pixel_t data_in,
  input logic   data_valid,
  input logic   data_ready,
  input acc_t   out_data,
  input logic   out_valid,
  input logic   out_ready,
  input logic   done
);

  // Sources hold valid and data until the beat transfers
  a_kernel_hold: assert property (@(posedge clk) disable iff (!arst_n_in)
    kernel_valid && !kernel_ready |=> kernel_valid && $stable(kernel_data))
    else $error("kernel beat dropped or changed before it transferred");

  a_data_hold: assert property (@(posedge clk) disable iff (!arst_n_in)
    data_valid && !data_ready |=> data_valid && $stable(data_in))
    else $error("data beat dropped or changed before it transferred");

  a_out_hold: assert property (@(posedge clk) disable iff (!arst_n_in)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else $error("result dropped or changed before it transferred");

  // Only one load phase at a time
  a_ready_excl: assert property (@(posedge clk) disable iff (!arst_n_in)
    !(kernel_ready && data_ready))
    else $error("kernel_ready and data_ready high together");

  a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n_in)
    done |=> !done)
    else $error("done held longer than one cycle");

endmodule

bind conv_top conv_checker u_checker (
  .clk(clk), .arst_n_in(arst_n_in),
  .kernel_data(kernel_data), .kernel_valid(kernel_valid), .kernel_ready(kernel_ready),
  .data_in(data_in), .data_valid(data_valid), .data_ready(data_ready),
  .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
  .done(done)
);

//--- dv/conv_tb.sv
// Runs one job at a time and expects the result count to follow from kernel size and stride alone
`timescale 1ns/1ps

module conv_tb import conv_pkg::*; ();

  localparam int STEP_TIMEOUT = 200;    // Cycles allowed for one beat
  localparam int DONE_TIMEOUT = 20000;  // Cycles allowed from last pixel to done

  logic    clk = 1'b0;
  logic    arst_n_in;
  logic    start;
  stride_e stride_mode;
  pixel_t  kernel_data;
  logic    kernel_valid;
  logic    kernel_ready;
  pixel_t  data_in;
  logic    data_valid;
  logic    data_ready;
  acc_t    out_data;
  logic    out_valid;
  logic    out_ready = 1'b0;
  logic    done;

  pixel_t kern [NB_TAPS];                   // Channel, row, column
  pixel_t fmap [NB_CH_IN][FMAP_H][FMAP_W];
  acc_t   exp_q [$];                        // Expected results of the running job
  bit     ready_pat [256];                  // Seeded out_ready pattern
  bit     bp_en;
  int     res_base;                         // Result index of the job's first result
  int     total_results = 0;
  int     total_done = 0;
  int     ready_idx = 0;
  int     mismatches = 0;
  int     count_errors = 0;
  int     timeouts = 0;
  int     tests_run = 0;
  int     tests_bad = 0;

  always #10 clk = ~clk;  // 20 ns period

  conv_top UUT (
    .clk(clk), .arst_n_in(arst_n_in), .start(start), .stride_mode(stride_mode),
    .kernel_data(kernel_data), .kernel_valid(kernel_valid), .kernel_ready(kernel_ready),
    .data_in(data_in), .data_valid(data_valid), .data_ready(data_ready),
    .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready), .done(done)
  );

  // Sum over channels and kernel offsets of pixel times weight
  function automatic acc_t ref_conv(input int ox, input int oy, input stride_e s);
    int step;
    int sum;
    step = (s == STRIDE_2) ? 2 : 1;
    sum  = 0;
    for (int c = 0; c < NB_CH_IN; c++) begin
      for (int ky = 0; ky < K_SIZE; ky++) begin
        for (int kx = 0; kx < K_SIZE; kx++) begin
          sum += int'(fmap[c][oy * step + ky][ox * step + kx])
                 * int'(kern[(c * K_SIZE + ky) * K_SIZE + kx]);
        end
      end
    end
    return acc_t'(sum);
  endfunction

  task automatic check_result(input acc_t got, input acc_t exp, input int idx);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH at %0t: result %0d is %0d, expected %0d", $time, idx, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      count_errors++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Compare each result as it transfers
  always @(posedge clk) begin : compare
    int idx;
    if (out_valid && out_ready) begin
      idx = total_results - res_base;
      if (idx < exp_q.size()) begin
        check_result(out_data, exp_q[idx], idx);
      end else begin
        mismatches++;  // Duplicate or stray result
        $display("ERROR at %0t: extra result %0d, job has only %0d", $time, idx, exp_q.size());
      end
      total_results <= total_results + 1;
    end
    if (done) total_done <= total_done + 1;
  end

  // Result sink, random low periods when enabled
  always @(posedge clk) begin
    out_ready <= bp_en ? ready_pat[ready_idx % 256] : 1'b1;
    ready_idx <= ready_idx + 1;
  end

  task automatic fill_random();
    foreach (kern[i]) kern[i] = pixel_t'($urandom());
    foreach (fmap[c, y, x]) fmap[c][y][x] = pixel_t'($urandom());
  endtask

  task automatic fill_const(input pixel_t v);
    foreach (kern[i]) kern[i] = v;
    foreach (fmap[c, y, x]) fmap[c][y][x] = v;
  endtask

  // Signs alternate over every address bit
  task automatic fill_extremes();
    foreach (kern[i]) kern[i] = (i % 2 == 1) ? pixel_t'(-128) : pixel_t'(127);
    foreach (fmap[c, y, x]) begin
      fmap[c][y][x] = (((c ^ y ^ x) & 1) == 1) ? pixel_t'(127) : pixel_t'(-128);
    end
  endtask

  task automatic send_kernel(input bit gaps, output bit ok);
    int t;
    ok = 1'b0;
    for (int i = 0; i < NB_TAPS; i++) begin
      if (gaps) begin
        kernel_valid <= 1'b0;
        repeat ($urandom_range(2)) @(posedge clk);
      end
      kernel_data  <= kern[i];
      kernel_valid <= 1'b1;
      t = 0;
      do begin
        @(posedge clk);
        t++;
      end while (!kernel_ready && t < STEP_TIMEOUT);
      if (!kernel_ready) begin
        timeouts++;
        $display("TIMEOUT at %0t: weight %0d was never accepted", $time, i);
        kernel_valid <= 1'b0;
        return;
      end
    end
    kernel_valid <= 1'b0;
    ok = 1'b1;
  endtask

  // Row, column, then channel innermost
  task automatic send_data(input bit gaps, output bit ok);
    int t;
    int c;
    int x;
    int y;
    ok = 1'b0;
    for (int p = 0; p < NB_PIXELS; p++) begin
      c = p % NB_CH_IN;
      x = (p / NB_CH_IN) % FMAP_W;
      y = p / (NB_CH_IN * FMAP_W);
      if (gaps) begin
        data_valid <= 1'b0;
        repeat ($urandom_range(2)) @(posedge clk);
      end
      data_in    <= fmap[c][y][x];
      data_valid <= 1'b1;
      t = 0;
      do begin
        @(posedge clk);
        t++;
      end while (!data_ready && t < STEP_TIMEOUT);
      if (!data_ready) begin
        timeouts++;
        $display("TIMEOUT at %0t: pixel %0d was never accepted", $time, p);
        data_valid <= 1'b0;
        return;
      end
    end
    data_valid <= 1'b0;
    ok = 1'b1;
  endtask

  // One full job checked against ref_conv
  task automatic run_job(input string name, input stride_e s, input bit gaps);
    int n_x;
    int n_y;
    int res0;
    int done0;
    int err0;
    int t;
    bit ok;
    if (timeouts != 0) return;  // DUT already stuck
    err0  = mismatches + count_errors + timeouts;
    n_x   = (FMAP_W - K_SIZE) / ((s == STRIDE_2) ? 2 : 1) + 1;
    n_y   = (FMAP_H - K_SIZE) / ((s == STRIDE_2) ? 2 : 1) + 1;
    res0  = total_results;
    done0 = total_done;
    exp_q.delete();
    for (int oy = 0; oy < n_y; oy++) begin
      for (int ox = 0; ox < n_x; ox++) begin
        exp_q.push_back(ref_conv(ox, oy, s));
      end
    end
    res_base = res0;
    stride_mode <= s;
    start       <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    send_kernel(gaps, ok);
    if (ok) send_data(gaps, ok);
    if (ok) begin
      t = 0;
      do begin
        @(posedge clk);
        t++;
      end while (!done && t < DONE_TIMEOUT);
      if (!done) begin
        timeouts++;
        $display("TIMEOUT at %0t: done never came after the data was loaded", $time);
      end else begin
        check_count(total_results - res0, n_x * n_y, "results before done");
        repeat (2) @(posedge clk);  // A stretched done lands in the count too
        check_count(total_done - done0, 1, "done pulses");
      end
    end
    tests_run++;
    if (mismatches + count_errors + timeouts == err0) begin
      $display("[%0t] %s: ok, %0d results", $time, name, total_results - res0);
    end else begin
      tests_bad++;
      $display("[%0t] %s: FAIL", $time, name);
    end
  endtask

  initial begin : main
    void'($urandom(32'h1e30ec89));
    arst_n_in    <= 1'b0;
    start        <= 1'b0;
    stride_mode  <= STRIDE_1;
    kernel_data  <= '0;
    kernel_valid <= 1'b0;
    data_in      <= '0;
    data_valid   <= 1'b0;
    bp_en        <= 1'b0;
    res_base = 0;
    foreach (ready_pat[i]) ready_pat[i] = ($urandom_range(3) != 0);  // Low about a quarter
    repeat (10) @(posedge clk);
    arst_n_in <= 1'b1;
    @(posedge clk);

    fill_random();
    run_job("stride 1 random", STRIDE_1, 1'b0);
    fill_random();
    run_job("stride 2 random", STRIDE_2, 1'b0);
    fill_random();
    bp_en <= 1'b1;
    run_job("stride 1 with out_ready gaps", STRIDE_1, 1'b0);
    run_job("stride 2 with out_ready gaps", STRIDE_2, 1'b0);
    bp_en <= 1'b0;
    fill_random();
    run_job("reference job without input gaps", STRIDE_1, 1'b0);
    run_job("same job with input gaps", STRIDE_1, 1'b1);
    fill_const(pixel_t'(-128));
    run_job("all -128", STRIDE_1, 1'b0);
    fill_extremes();
    run_job("mixed extremes stride 2", STRIDE_2, 1'b0);
    run_job("mixed extremes stride 1", STRIDE_1, 1'b1);

    $display("Summary: %0d tests, %0d with errors, %0d mismatches, %0d count errors, %0d timeouts",
             tests_run, tests_bad, mismatches, count_errors, timeouts);
    if (tests_bad == 0 && mismatches + count_errors + timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- hw/conv_ctrl.sv
// Assumes each job runs to completion because phases only advance on pulses from the datapath
`timescale 1ns/1ps

module conv_ctrl import conv_pkg::*; (
  input  logic   clk,
  input  logic   arst_n_in,
  input  logic   start,
  input  logic   kernel_loaded,  // Last weight accepted
  input  logic   data_loaded,    // Last pixel accepted
  input  logic   walk_done,      // Last tap issued
  input  logic   drained,        // Last result transferred
  output phase_e phase,
  output logic   done
);

  phase_e phase_next;

  // Phase register
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      phase <= IDLE;
    end else begin
      phase <= phase_next;
    end
  end

  // Each phase waits for exactly one event
  always_comb begin
    phase_next = phase;  // Hold by default
    case (phase)
      IDLE: begin
        if (start) begin
          phase_next = LOAD_KERNEL;
        end
      end
      LOAD_KERNEL: begin
        if (kernel_loaded) begin
          phase_next = LOAD_DATA;
        end
      end
      LOAD_DATA: begin
        if (data_loaded) begin
          phase_next = CONVOLVE;
        end
      end
      CONVOLVE: begin
        // Taps may still be in flight, results drain afterwards
        if (walk_done) begin
          phase_next = DRAIN;
        end
      end
      DRAIN: begin
        if (drained) begin
          phase_next = DONE;
        end
      end
      DONE: begin
        phase_next = IDLE;  // Single cycle
      end
      default: begin
        phase_next = IDLE;  // Recover from unused encodings
      end
    endcase
  end

  // Done pulse straight from the phase
  assign done = (phase == DONE);

endmodule

//--- hw/conv_loader.sv
// Weights must arrive channel then row then column and pixels row then column then channel
`timescale 1ns/1ps

module conv_loader import conv_pkg::*; (
  input  logic   clk,
  input  logic   arst_n_in,
  input  phase_e phase,
  input  pixel_t kernel_data,
  input  logic   kernel_valid,
  output logic   kernel_ready,
  input  pixel_t data_in,
  input  logic   data_valid,
  output logic   data_ready,
  output logic   kernel_loaded,
  output logic   data_loaded,
  input  coord_t rd_x,
  input  coord_t rd_y,
  input  chan_t  rd_ch,
  input  tap_t   tap,
  input  logic   tap_valid,
  input  logic   last_tap_in,
  input  logic   stall,
  output pixel_t rd_pixel,
  output pixel_t rd_weight,
  output logic   rd_valid,
  output logic   rd_last
);

  pixel_t kbank [NB_TAPS];                    // Kernel register bank
  pixel_t fmem  [NB_CH_IN][NB_PIXELS/NB_CH_IN];  // One plane per channel, addressed {y, x}

  tap_t   k_cnt;   // Next weight slot
  coord_t ld_x;
  coord_t ld_y;
  chan_t  ld_ch;
  logic   k_beat;
  logic   d_beat;
  logic   ld_last_x;
  logic   ld_last_y;
  logic   ld_last_ch;
  logic   rd_en;

  assign kernel_ready = (phase == LOAD_KERNEL);
  assign data_ready   = (phase == LOAD_DATA);
  assign k_beat       = kernel_valid && kernel_ready;
  assign d_beat       = data_valid && data_ready;

  assign ld_last_x  = (ld_x == coord_t'(FMAP_W - 1));
  assign ld_last_y  = (ld_y == coord_t'(FMAP_H - 1));
  assign ld_last_ch = (ld_ch == chan_t'(NB_CH_IN - 1));

  assign kernel_loaded = k_beat && (k_cnt == tap_t'(NB_TAPS - 1));
  assign data_loaded   = d_beat && ld_last_ch && ld_last_x && ld_last_y;

  // Load counters, cleared outside their phase
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      k_cnt <= '0;
      ld_x  <= '0;
      ld_y  <= '0;
      ld_ch <= '0;
    end else begin
      if (!kernel_ready) k_cnt <= '0;
      else if (k_beat)   k_cnt <= k_cnt + tap_t'(1);
      if (!data_ready) begin
        ld_x  <= '0;
        ld_y  <= '0;
        ld_ch <= '0;
      end else if (d_beat) begin
        ld_ch <= ld_last_ch ? '0 : ld_ch + 1'b1;  // Channel innermost
        if (ld_last_ch) ld_x <= ld_last_x ? '0 : ld_x + coord_t'(1);
        if (ld_last_ch && ld_last_x) ld_y <= ld_y + coord_t'(1);  // Wraps after last row
      end
    end
  end

  // Storage writes
  always_ff @(posedge clk) begin
    if (k_beat) kbank[k_cnt] <= kernel_data;
    if (d_beat) fmem[ld_ch][{ld_y, ld_x}] <= data_in;
  end

  assign rd_en = tap_valid && !stall;  // Read register freezes on back-pressure

  // Registered read port, one cycle latency
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pixel  <= fmem[rd_ch][{rd_y, rd_x}];
      rd_weight <= kbank[tap];
    end
  end

  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      rd_valid <= 1'b0;
      rd_last  <= 1'b0;
    end else if (!stall) begin
      rd_valid <= tap_valid;
      rd_last  <= tap_valid && last_tap_in;  // Marks end of window
    end
  end

endmodule

//--- hw/conv_mac.sv
// Taps of one window must arrive back to back in order with the last one flagged by rd_last
`timescale 1ns/1ps

module conv_mac import conv_pkg::*; (
  input  logic   clk,
  input  logic   arst_n_in,
  input  pixel_t rd_pixel,
  input  pixel_t rd_weight,
  input  logic   rd_valid,
  input  logic   rd_last,
  input  logic   stall,
  output logic   acc_valid,
  output acc_t   acc_result
);

  acc_t product;
  acc_t acc_q;
  logic first_q;  // Next tap opens a new window
  logic take;

  // Signed 8x8 product, sign extended to the accumulator
  assign product = acc_t'(rd_pixel) * acc_t'(rd_weight);

  assign take = rd_valid && !stall;

  // Window framing and result strobe
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      first_q   <= 1'b1;
      acc_valid <= 1'b0;
    end else if (!stall) begin
      acc_valid <= rd_valid && rd_last;  // Held while stalled
      if (rd_valid) first_q <= rd_last;
    end
  end

  // Running sum
  always_ff @(posedge clk) begin
    if (take) begin
      acc_q <= (first_q ? acc_t'(0) : acc_q) + product;  // Restart on first tap
    end
  end

  assign acc_result = acc_q;

endmodule

//--- hw/conv_out.sv
// Holds at most one result so the whole datapath freezes whenever a result is refused
`timescale 1ns/1ps

module conv_out import conv_pkg::*; (
  input  logic    clk,
  input  logic    arst_n_in,
  input  phase_e  phase,
  input  stride_e stride_mode,
  input  logic    acc_valid,
  input  acc_t    acc_result,
  input  logic    out_ready,
  output logic    out_valid,
  output acc_t    out_data,
  output logic    stall,
  output logic    drained
);

  stride_e    stride_q;
  logic [5:0] res_cnt;  // Results sent this job
  logic [5:0] res_last;
  logic       xfer;

  assign stall    = out_valid && !out_ready;
  assign xfer     = out_valid && out_ready;
  assign res_last = (stride_q == STRIDE_2) ? 6'(NB_OUT_S2 - 1) : 6'(NB_OUT_S1 - 1);
  assign drained  = xfer && (res_cnt == res_last);

  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      stride_q  <= STRIDE_1;
      res_cnt   <= '0;
      out_valid <= 1'b0;
    end else begin
      if (phase != CONVOLVE && phase != DRAIN) stride_q <= stride_mode;  // Frozen while busy
      if (phase == IDLE) res_cnt <= '0;
      else if (xfer)     res_cnt <= res_cnt + 6'd1;
      if (!stall) out_valid <= acc_valid;  // Refill or empty when slot frees
    end
  end

  // Holding register
  always_ff @(posedge clk) begin
    if (acc_valid && !stall) out_data <= acc_result;
  end

endmodule

//--- hw/conv_pkg.sv
// Sizes are fixed at elaboration and the engine supports only a 3x3 kernel over an 8x8 two-channel map
package conv_pkg;

  // Feature map geometry
  localparam int FMAP_W    = 8;
  localparam int FMAP_H    = 8;
  localparam int NB_CH_IN  = 2;
  localparam int K_SIZE    = 3;
  localparam int NB_TAPS   = K_SIZE * K_SIZE * NB_CH_IN;  // 18 products per output
  localparam int NB_PIXELS = FMAP_W * FMAP_H * NB_CH_IN;  // Data beats per job

  // Datapath widths
  localparam int PIX_W = 8;
  localparam int ACC_W = 24;  // 18 products of 16 bits fit with margin

  // Results per job for each stride
  localparam int NB_OUT_S1 = (FMAP_W - K_SIZE + 1) * (FMAP_H - K_SIZE + 1);
  localparam int NB_OUT_S2 = ((FMAP_W - K_SIZE) / 2 + 1) * ((FMAP_H - K_SIZE) / 2 + 1);

  typedef logic signed [PIX_W-1:0] pixel_t;  // Pixel or weight
  typedef logic signed [ACC_W-1:0] acc_t;    // One convolution result
  typedef logic [2:0] coord_t;               // Map coordinate, 0..7
  typedef logic chan_t;                      // Input channel index
  typedef logic [4:0] tap_t;                 // Tap index, 0..17

  // Step between output windows
  typedef enum logic {
    STRIDE_1,
    STRIDE_2
  } stride_e;

  // Job phases of the controller
  typedef enum logic [2:0] {
    IDLE,
    LOAD_KERNEL,
    LOAD_DATA,
    CONVOLVE,
    DRAIN,
    DONE
  } phase_e;

endpackage

//--- hw/conv_top.sv
// One start gives one output channel and stride_mode must stay stable from start until done
`timescale 1ns/1ps

module conv_top import conv_pkg::*; (
  input  logic    clk,
  input  logic    arst_n_in,
  input  logic    start,
  input  stride_e stride_mode,
  input  pixel_t  kernel_data,
  input  logic    kernel_valid,
  output logic    kernel_ready,
  input  pixel_t  data_in,
  input  logic    data_valid,
  output logic    data_ready,
  output acc_t    out_data,
  output logic    out_valid,
  input  logic    out_ready,
  output logic    done
);

  phase_e phase;
  logic   kernel_loaded;
  logic   data_loaded;
  logic   walk_done;
  logic   drained;
  coord_t rd_x;
  coord_t rd_y;
  chan_t  rd_ch;
  tap_t   tap;
  logic   tap_valid;
  logic   last_tap;
  pixel_t rd_pixel;
  pixel_t rd_weight;
  logic   rd_valid;
  logic   rd_last;
  logic   acc_valid;
  acc_t   acc_result;
  logic   stall;  // Back-pressure from the result stream

  // Phase sequencing
  conv_ctrl u_ctrl (
    .clk(clk), .arst_n_in(arst_n_in), .start(start),
    .kernel_loaded(kernel_loaded), .data_loaded(data_loaded),
    .walk_done(walk_done), .drained(drained), .phase(phase), .done(done)
  );

  // Kernel bank and feature memory
  conv_loader u_loader (
    .clk(clk), .arst_n_in(arst_n_in), .phase(phase),
    .kernel_data(kernel_data), .kernel_valid(kernel_valid), .kernel_ready(kernel_ready),
    .data_in(data_in), .data_valid(data_valid), .data_ready(data_ready),
    .kernel_loaded(kernel_loaded), .data_loaded(data_loaded),
    .rd_x(rd_x), .rd_y(rd_y), .rd_ch(rd_ch), .tap(tap),
    .tap_valid(tap_valid), .last_tap_in(last_tap), .stall(stall),
    .rd_pixel(rd_pixel), .rd_weight(rd_weight), .rd_valid(rd_valid), .rd_last(rd_last)
  );

  // Window walk
  conv_window u_window (
    .clk(clk), .arst_n_in(arst_n_in), .phase(phase), .stride_mode(stride_mode),
    .stall(stall), .rd_x(rd_x), .rd_y(rd_y), .rd_ch(rd_ch), .tap(tap),
    .tap_valid(tap_valid), .last_tap(last_tap), .walk_done(walk_done)
  );

  conv_mac u_mac (
    .clk(clk), .arst_n_in(arst_n_in), .rd_pixel(rd_pixel), .rd_weight(rd_weight),
    .rd_valid(rd_valid), .rd_last(rd_last), .stall(stall),
    .acc_valid(acc_valid), .acc_result(acc_result)
  );

  // Result stream
  conv_out u_out (
    .clk(clk), .arst_n_in(arst_n_in), .phase(phase), .stride_mode(stride_mode),
    .acc_valid(acc_valid), .acc_result(acc_result), .out_ready(out_ready),
    .out_valid(out_valid), .out_data(out_data), .stall(stall), .drained(drained)
  );

endmodule

//--- hw/conv_window.sv
// Stride is taken from the input on the cycle before convolution starts and must stay stable until then
`timescale 1ns/1ps

module conv_window import conv_pkg::*; (
  input  logic    clk,
  input  logic    arst_n_in,
  input  phase_e  phase,
  input  stride_e stride_mode,
  input  logic    stall,
  output coord_t  rd_x,
  output coord_t  rd_y,
  output chan_t   rd_ch,
  output tap_t    tap,
  output logic    tap_valid,
  output logic    last_tap,
  output logic    walk_done
);

  stride_e    stride_q;
  coord_t     step;
  coord_t     base_x;  // Window origin in input coordinates
  coord_t     base_y;
  logic [1:0] kx;
  logic [1:0] ky;
  chan_t      ch;
  logic       issue;
  logic       last_kx;
  logic       last_ky;
  logic       last_ch;
  logic       last_x;
  logic       last_y;

  // Stride frozen for the whole walk
  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      stride_q <= STRIDE_1;
    end else if (phase != CONVOLVE) begin
      stride_q <= stride_mode;
    end
  end

  assign step = (stride_q == STRIDE_2) ? coord_t'(2) : coord_t'(1);

  assign tap_valid = (phase == CONVOLVE);  // One tap every free cycle
  assign issue     = tap_valid && !stall;

  assign last_kx  = (kx == 2'(K_SIZE - 1));
  assign last_ky  = (ky == 2'(K_SIZE - 1));
  assign last_ch  = (ch == chan_t'(NB_CH_IN - 1));
  assign last_tap = (tap == tap_t'(NB_TAPS - 1));
  // No room for another window past this origin
  assign last_x   = int'(base_x) + K_SIZE - 1 + int'(step) >= FMAP_W;
  assign last_y   = int'(base_y) + K_SIZE - 1 + int'(step) >= FMAP_H;

  assign walk_done = issue && last_tap && last_x && last_y;

  // Read address from origin plus kernel offset
  assign rd_x  = base_x + coord_t'(kx);
  assign rd_y  = base_y + coord_t'(ky);
  assign rd_ch = ch;

  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      base_x <= '0;
      base_y <= '0;
      kx     <= '0;
      ky     <= '0;
      ch     <= '0;
      tap    <= '0;
    end else if (phase != CONVOLVE) begin
      base_x <= '0;  // Ready for the next walk
      base_y <= '0;
      kx     <= '0;
      ky     <= '0;
      ch     <= '0;
      tap    <= '0;
    end else if (issue) begin
      tap <= last_tap ? '0 : tap + tap_t'(1);
      kx  <= last_kx ? '0 : kx + 2'd1;
      if (last_kx) ky <= last_ky ? '0 : ky + 2'd1;
      if (last_kx && last_ky) ch <= last_ch ? '0 : ch + 1'b1;
      // Raster order, x inner
      if (last_tap) base_x <= last_x ? '0 : base_x + step;
      if (last_tap && last_x) base_y <= last_y ? '0 : base_y + step;
    end
  end

endmodule
